/* files.f */
hw/ipod_pkg.sv
hw/key_command_fsm.sv
hw/sample_rate_gen.sv
hw/flash_read_seq.sv
hw/address_walker.sv
hw/ipod_player.sv
tests/tb_ipod_player.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_ipod_player -f files.f \
  && ./obj_dir/Vtb_ipod_player > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "TEST PASSED" sim.log \
  && echo "Simulation result: pass" \
  || { echo "Simulation result: fail"; exit 1; }

/* tests/tb_ipod_player.sv */
`default_nettype none

module tb_ipod_player;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'd25364;
  localparam int RANDOM_SEGMENTS = 60;
  localparam int VALID_TIMEOUT = 400;
  localparam ipod_pkg::ascii_t KEY_OTHER = 8'h58;

  logic                 clk;
  logic                 rst;
  ipod_pkg::ascii_t     key_ascii;
  ipod_pkg::speed_cmd_t speed_cmd;
  ipod_pkg::sample_t    flash_dq;
  ipod_pkg::flash_bus_t flash_bus;
  ipod_pkg::sample_t    sample;
  logic                 sample_valid;
  ipod_pkg::play_ctrl_t play_ctrl;

  // Reference model state, updated on the rising edge
  ipod_pkg::play_state_e m_state;
  ipod_pkg::period_t     m_period;
  // Clocks left in the current tick interval
  ipod_pkg::period_t     m_left;
  ipod_pkg::addr_t       m_addr;
  ipod_pkg::sample_t     m_sample;
  logic                  m_valid;
  int                    m_rd_left;
  int                    since_strobe;
  int                    since_stop;
  bit                    play_key_seen;

  logic [31:0] rng;
  bit          strobes_on;
  int          value_errors;
  int          other_errors;
  int          since_valid;
  bit          valid_seen;

  ipod_player i_ipod_player (
    .clk          (clk),
    .rst          (rst),
    .key_ascii    (key_ascii),
    .speed_cmd    (speed_cmd),
    .flash_dq     (flash_dq),
    .flash_bus    (flash_bus),
    .sample       (sample),
    .sample_valid (sample_valid),
    .play_ctrl    (play_ctrl)
  );

  initial
  begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  // ============================================================
  // Flash contents and model rules
  // ============================================================
  function automatic ipod_pkg::sample_t flash_byte(input ipod_pkg::addr_t a);
    return a[7:0] ^ a[15:8];
  endfunction

  assign flash_dq = flash_byte(flash_bus.addr);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic ipod_pkg::play_state_e next_play_state(
    input ipod_pkg::play_state_e s, input ipod_pkg::ascii_t k);
    ipod_pkg::play_state_e n;
    n = s;
    case (s)
      ipod_pkg::ST_INIT:
        n = ipod_pkg::ST_STOP;
      ipod_pkg::ST_STOP:
        if (k == ipod_pkg::KEY_PLAY) n = ipod_pkg::ST_PLAY;
      ipod_pkg::ST_PLAY:
        if (k == ipod_pkg::KEY_STOP) n = ipod_pkg::ST_STOP;
        else if (k == ipod_pkg::KEY_BACK) n = ipod_pkg::ST_PLAY_BACK;
        else if (k == ipod_pkg::KEY_RESTART) n = ipod_pkg::ST_RESTART;
      ipod_pkg::ST_PLAY_BACK:
        if (k == ipod_pkg::KEY_FORWARD) n = ipod_pkg::ST_PLAY;
        else if (k == ipod_pkg::KEY_STOP) n = ipod_pkg::ST_STOP_BACK;
      ipod_pkg::ST_STOP_BACK:
        if (k == ipod_pkg::KEY_PLAY) n = ipod_pkg::ST_PLAY_BACK;
      ipod_pkg::ST_RESTART:
        if (k != ipod_pkg::KEY_RESTART) n = ipod_pkg::ST_PLAY;
      default:
        n = ipod_pkg::ST_INIT;
    endcase
    return n;
  endfunction

  function automatic ipod_pkg::play_ctrl_t expected_ctrl(input ipod_pkg::play_state_e s);
    ipod_pkg::play_ctrl_t c;
    c.playing = (s == ipod_pkg::ST_PLAY) || (s == ipod_pkg::ST_PLAY_BACK);
    c.reverse = (s == ipod_pkg::ST_PLAY_BACK) || (s == ipod_pkg::ST_STOP_BACK);
    c.restart = (s == ipod_pkg::ST_RESTART);
    return c;
  endfunction

  function automatic ipod_pkg::period_t next_period(
    input ipod_pkg::period_t p, input ipod_pkg::speed_cmd_t cmd);
    int v;
    v = int'(p);
    if (cmd.to_default) v = int'(ipod_pkg::DEFAULT_PERIOD);
    else if (cmd.up) v = v - int'(ipod_pkg::RATE_STEP);
    else if (cmd.down) v = v + int'(ipod_pkg::RATE_STEP);
    if (v < int'(ipod_pkg::MIN_PERIOD)) v = int'(ipod_pkg::MIN_PERIOD);
    if (v > int'(ipod_pkg::MAX_PERIOD)) v = int'(ipod_pkg::MAX_PERIOD);
    return ipod_pkg::period_t'(v);
  endfunction

  // ============================================================
  // Reference model, one step per clock from pre-edge values
  // ============================================================
  always @(posedge clk or posedge rst)
  begin
    ipod_pkg::play_ctrl_t c;
    ipod_pkg::period_t    p_next;
    logic                 tick;
    logic                 valid_next;
    if (rst)
    begin
      m_state       = ipod_pkg::ST_INIT;
      m_period      = ipod_pkg::DEFAULT_PERIOD;
      m_left        = ipod_pkg::DEFAULT_PERIOD;
      m_addr        = '0;
      m_sample      = '0;
      m_valid       = 1'b0;
      m_rd_left     = 0;
      since_strobe  = 0;
      since_stop    = 0;
      play_key_seen = 1'b0;
    end
    else
    begin
      c          = expected_ctrl(m_state);
      tick       = (m_left == 16'd1);
      p_next     = next_period(m_period, speed_cmd);
      valid_next = 1'b0;
      if (m_rd_left > 0)
      begin
        m_rd_left = m_rd_left - 1;
        if (m_rd_left == 0)
        begin
          valid_next = 1'b1;
          m_sample   = flash_byte(m_addr);
        end
      end
      else if (tick && c.playing)
        m_rd_left = int'(ipod_pkg::READ_WAIT_CYCLES);
      // Step follows the presented sample, restart pins the start
      if (c.restart)
        m_addr = '0;
      else if (m_valid && c.reverse)
        m_addr = (m_addr == '0) ? ipod_pkg::LAST_ADDR : m_addr - 22'd1;
      else if (m_valid)
        m_addr = (m_addr == ipod_pkg::LAST_ADDR) ? '0 : m_addr + 22'd1;
      if (tick)
      begin
        m_left = p_next;
      end
      else
      begin
        m_left = m_left - 16'd1;
      end
      since_strobe = (speed_cmd != '0) ? 0 : since_strobe + 1;
      since_stop   = c.playing ? since_stop + 1 : 0;
      if (key_ascii == ipod_pkg::KEY_PLAY) play_key_seen = 1'b1;
      m_period = p_next;
      m_valid  = valid_next;
      m_state  = next_play_state(m_state, key_ascii);
    end
  end

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    value_errors++;
    $display("** Error: %s dut=%h exp=%h at %0t", name, got, exp, $time);
  endtask

  // ============================================================
  // Output checks on the falling edge
  // ============================================================
  always @(negedge clk)
  begin
    ipod_pkg::play_ctrl_t c;
    c = expected_ctrl(m_state);
    since_valid++;
    if (play_ctrl != c)
      report_value("play_ctrl", 32'(play_ctrl), 32'(c));
    if (flash_bus.ce_n != (m_rd_left == 0))
      report_value("flash_bus.ce_n", 32'(flash_bus.ce_n), 32'(m_rd_left == 0));
    if (flash_bus.oe_n != (m_rd_left == 0))
      report_value("flash_bus.oe_n", 32'(flash_bus.oe_n), 32'(m_rd_left == 0));
    if (flash_bus.addr != m_addr)
      report_value("flash_bus.addr", 32'(flash_bus.addr), 32'(m_addr));
    if (sample_valid != m_valid)
      report_value("sample_valid", 32'(sample_valid), 32'(m_valid));
    if (sample_valid && m_valid && sample != m_sample)
      report_value("sample", 32'(sample), 32'(m_sample));
    if (sample_valid && !play_key_seen)
    begin
      other_errors++;
      $display("A sample was presented before any play key at %0t", $time);
    end
    if (sample_valid)
    begin
      // Only spacings with steady speed and uninterrupted play
      if (valid_seen && since_strobe > since_valid + 10 && since_stop > since_valid + 10)
        if (since_valid != int'(m_period))
          report_value("sample_valid spacing", 32'(since_valid), 32'(m_period));
      valid_seen  = 1'b1;
      since_valid = 0;
    end
  end

  // ============================================================
  // Stimulus
  // ============================================================
  task automatic drive_key(input ipod_pkg::ascii_t k, input int n);
    for (int i = 0; i < n; i++)
    begin
      @(negedge clk);
      key_ascii = k;
      speed_cmd = '0;
      rng       = xorshift32(rng);
      if (strobes_on && rng[5:0] == 6'd0)
      begin
        speed_cmd.up         = rng[8];
        speed_cmd.down       = rng[9];
        speed_cmd.to_default = (rng[12:10] == 3'd0);
      end
    end
  endtask

  task automatic pulse_speed(input ipod_pkg::speed_cmd_t cmd, input int gap);
    @(negedge clk);
    speed_cmd = cmd;
    @(negedge clk);
    speed_cmd = '0;
    drive_key(key_ascii, gap);
  endtask

  task automatic wait_for_sample(input int timeout);
    bit found;
    found = 1'b0;
    for (int i = 0; i < timeout && !found; i++)
    begin
      @(negedge clk);
      speed_cmd = '0;
      if (sample_valid) found = 1'b1;
    end
    if (!found)
    begin
      other_errors++;
      $display("Timed out waiting for sample_valid after %0d clocks", timeout);
      $display("Errors: %0d value, %0d other", value_errors, other_errors);
      $display("TEST FAILED");
      $finish;
    end
  endtask

  initial
  begin
    ipod_pkg::ascii_t key_table[6];
    ipod_pkg::speed_cmd_t cmd;
    int idx;
    int len;
    key_table = '{ipod_pkg::KEY_PLAY, ipod_pkg::KEY_STOP, ipod_pkg::KEY_BACK,
                  ipod_pkg::KEY_FORWARD, ipod_pkg::KEY_RESTART, KEY_OTHER};
    rst          = 1'b1;
    key_ascii    = '0;
    speed_cmd    = '0;
    rng          = SEED;
    strobes_on   = 1'b0;
    value_errors = 0;
    other_errors = 0;
    since_valid  = 0;
    valid_seen   = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // Idle, then forward play
    drive_key(KEY_OTHER, 100);
    drive_key(ipod_pkg::KEY_PLAY, 5);
    wait_for_sample(VALID_TIMEOUT);
    drive_key(KEY_OTHER, 300);

    // Speed ladder into both clamps and back to default
    cmd = '{up: 1'b1, down: 1'b0, to_default: 1'b0};
    repeat (8) pulse_speed(cmd, 100);
    cmd = '{up: 1'b0, down: 1'b1, to_default: 1'b0};
    repeat (22) pulse_speed(cmd, 220);
    cmd = '{up: 1'b0, down: 1'b0, to_default: 1'b1};
    pulse_speed(cmd, 200);

    // Stop and resume, restart, then backward across address 0
    drive_key(ipod_pkg::KEY_STOP, 20);
    drive_key(KEY_OTHER, 100);
    drive_key(ipod_pkg::KEY_PLAY, 5);
    drive_key(KEY_OTHER, 200);
    drive_key(ipod_pkg::KEY_RESTART, 150);
    drive_key(KEY_OTHER, 50);
    drive_key(ipod_pkg::KEY_BACK, 300);
    drive_key(ipod_pkg::KEY_FORWARD, 200);
    drive_key(ipod_pkg::KEY_STOP, 50);

    strobes_on = 1'b1;
    for (int s = 0; s < RANDOM_SEGMENTS; s++)
    begin
      rng = xorshift32(rng);
      idx = int'(rng % 32'd6);
      len = 1 + int'((rng >> 8) % 32'd400);
      drive_key(key_table[idx], len);
    end
    strobes_on = 1'b0;
    drive_key(KEY_OTHER, 20);

    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/ipod_player.sv */
`default_nettype none

module ipod_player (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire ipod_pkg::ascii_t     key_ascii,
  input  wire ipod_pkg::speed_cmd_t speed_cmd,
  input  wire ipod_pkg::sample_t    flash_dq,
  output ipod_pkg::flash_bus_t      flash_bus,
  output ipod_pkg::sample_t         sample,
  output logic                      sample_valid,
  output ipod_pkg::play_ctrl_t      play_ctrl
);

  logic            tick;
  logic            step;
  logic            ce_n;
  logic            oe_n;
  ipod_pkg::addr_t addr;

  // ============================================================
  // Decode and execute stages
  // ============================================================
  key_command_fsm i_key_command_fsm (
    .clk       (clk),
    .rst       (rst),
    .key_ascii (key_ascii),
    .play_ctrl (play_ctrl)
  );

  sample_rate_gen i_sample_rate_gen (
    .clk       (clk),
    .rst       (rst),
    .speed_cmd (speed_cmd),
    .tick      (tick)
  );

  flash_read_seq i_flash_read_seq (
    .clk          (clk),
    .rst          (rst),
    .tick         (tick),
    .playing      (play_ctrl.playing),
    .flash_dq     (flash_dq),
    .flash_ce_n   (ce_n),
    .flash_oe_n   (oe_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .step         (step)
  );

  address_walker i_address_walker (
    .clk     (clk),
    .rst     (rst),
    .step    (step),
    .reverse (play_ctrl.reverse),
    .restart (play_ctrl.restart),
    .addr    (addr)
  );

  // Flash pins gathered into one bus
  always_comb
  begin
    flash_bus.addr = addr;
    flash_bus.ce_n = ce_n;
    flash_bus.oe_n = oe_n;
  end

endmodule

`default_nettype wire

/* hw/address_walker.sv */
`default_nettype none

module address_walker (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            step,
  input  wire logic            reverse,
  input  wire logic            restart,
  output ipod_pkg::addr_t      addr
);

  ipod_pkg::addr_t addr_up;
  ipod_pkg::addr_t addr_down;

  // ============================================================
  // Neighbour addresses, wrapping inside the sample region
  // ============================================================
  always_comb
  begin
    if (addr == ipod_pkg::LAST_ADDR)
      addr_up = '0;
    else
      addr_up = addr + 22'd1;

    if (addr == '0)
      addr_down = ipod_pkg::LAST_ADDR;
    else
      addr_down = addr - 22'd1;
  end

  // Restart pins the address to zero and overrides any step
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      addr <= '0;
    end
    else if (restart)
    begin
      addr <= '0;
    end
    else if (step)
    begin
      if (reverse)
        addr <= addr_down;
      else
        addr <= addr_up;
    end
  end

endmodule

`default_nettype wire

/* hw/flash_read_seq.sv */
`default_nettype none

module flash_read_seq (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              tick,
  input  wire logic              playing,
  input  wire ipod_pkg::sample_t flash_dq,
  output logic                   flash_ce_n,
  output logic                   flash_oe_n,
  output ipod_pkg::sample_t      sample,
  output logic                   sample_valid,
  output logic                   step
);

  logic                rd_busy;
  ipod_pkg::wait_cnt_t wait_cnt;
  logic                rd_last;

  // Final clock of the enable window
  assign rd_last = rd_busy && (wait_cnt == ipod_pkg::WAIT_LAST);

  // ============================================================
  // Read window
  // ============================================================
  // Ticks landing inside a window are dropped
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rd_busy  <= 1'b0;
      wait_cnt <= '0;
    end
    else if (!rd_busy)
    begin
      if (tick && playing)
      begin
        rd_busy  <= 1'b1;
        wait_cnt <= '0;
      end
    end
    else if (rd_last)
    begin
      rd_busy <= 1'b0;
    end
    else
    begin
      wait_cnt <= wait_cnt + ipod_pkg::wait_cnt_t'(1);
    end
  end

  // Chip and output enable share one window
  always_comb
  begin
    flash_ce_n = !rd_busy;
    flash_oe_n = !rd_busy;
  end

  // ============================================================
  // Byte capture
  // ============================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sample       <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= rd_last;
      if (rd_last)
        sample <= flash_dq;
    end
  end

  // Address moves on in the same cycle the sample is presented
  assign step = sample_valid;

endmodule

`default_nettype wire

/* hw/sample_rate_gen.sv */
`default_nettype none

module sample_rate_gen (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire ipod_pkg::speed_cmd_t speed_cmd,
  output logic                      tick
);

  ipod_pkg::period_t period_q;
  ipod_pkg::period_t period_d;
  ipod_pkg::period_t active_period;
  ipod_pkg::period_t count;

  // ============================================================
  // Period register with clamped steps
  // ============================================================
  // Default beats faster, faster beats slower
  always_comb
  begin
    period_d = period_q;
    if (speed_cmd.to_default)
    begin
      period_d = ipod_pkg::DEFAULT_PERIOD;
    end
    else if (speed_cmd.up)
    begin
      if (period_q >= ipod_pkg::MIN_PERIOD + ipod_pkg::RATE_STEP)
        period_d = period_q - ipod_pkg::RATE_STEP;
      else
        period_d = ipod_pkg::MIN_PERIOD;
    end
    else if (speed_cmd.down)
    begin
      if (period_q <= ipod_pkg::MAX_PERIOD - ipod_pkg::RATE_STEP)
        period_d = period_q + ipod_pkg::RATE_STEP;
      else
        period_d = ipod_pkg::MAX_PERIOD;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      period_q <= ipod_pkg::DEFAULT_PERIOD;
    end
    else
    begin
      period_q <= period_d;
    end
  end

  // ============================================================
  // Tick divider
  // ============================================================
  // Interval length is frozen until the current interval ends
  assign tick = (count == active_period - 16'd1);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      count         <= '0;
      active_period <= ipod_pkg::DEFAULT_PERIOD;
    end
    else if (tick)
    begin
      count         <= '0;
      active_period <= period_d;
    end
    else
    begin
      count <= count + 16'd1;
    end
  end

endmodule

`default_nettype wire

/* hw/key_command_fsm.sv */
`default_nettype none

module key_command_fsm (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire ipod_pkg::ascii_t    key_ascii,
  output ipod_pkg::play_ctrl_t     play_ctrl
);

  ipod_pkg::play_state_e state;
  ipod_pkg::play_state_e next_state;

  // ============================================================
  // State register
  // ============================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= ipod_pkg::ST_INIT;
    end
    else
    begin
      state <= next_state;
    end
  end

  // Keys not listed for a state leave it where it is
  always_comb
  begin
    next_state = state;
    case (state)
      ipod_pkg::ST_INIT:
      begin
        next_state = ipod_pkg::ST_STOP;
      end
      ipod_pkg::ST_STOP:
      begin
        if (key_ascii == ipod_pkg::KEY_PLAY)
          next_state = ipod_pkg::ST_PLAY;
      end
      ipod_pkg::ST_PLAY:
      begin
        if (key_ascii == ipod_pkg::KEY_STOP)
          next_state = ipod_pkg::ST_STOP;
        else if (key_ascii == ipod_pkg::KEY_BACK)
          next_state = ipod_pkg::ST_PLAY_BACK;
        else if (key_ascii == ipod_pkg::KEY_RESTART)
          next_state = ipod_pkg::ST_RESTART;
      end
      ipod_pkg::ST_PLAY_BACK:
      begin
        if (key_ascii == ipod_pkg::KEY_FORWARD)
          next_state = ipod_pkg::ST_PLAY;
        else if (key_ascii == ipod_pkg::KEY_STOP)
          next_state = ipod_pkg::ST_STOP_BACK;
      end
      ipod_pkg::ST_STOP_BACK:
      begin
        if (key_ascii == ipod_pkg::KEY_PLAY)
          next_state = ipod_pkg::ST_PLAY_BACK;
      end
      ipod_pkg::ST_RESTART:
      begin
        // Hold at the start until R is let go
        if (key_ascii != ipod_pkg::KEY_RESTART)
          next_state = ipod_pkg::ST_PLAY;
      end
      default:
      begin
        next_state = ipod_pkg::ST_INIT;
      end
    endcase
  end

  // ============================================================
  // Status decode, straight from the state
  // ============================================================
  always_comb
  begin
    play_ctrl.playing = (state == ipod_pkg::ST_PLAY) ||
                        (state == ipod_pkg::ST_PLAY_BACK);
    play_ctrl.reverse = (state == ipod_pkg::ST_PLAY_BACK) ||
                        (state == ipod_pkg::ST_STOP_BACK);
    play_ctrl.restart = (state == ipod_pkg::ST_RESTART);
  end

endmodule

`default_nettype wire

/* hw/ipod_pkg.sv */
`default_nettype none

package ipod_pkg;

  // ============================================================
  // Vector types
  // ============================================================
  typedef logic [21:0] addr_t;
  typedef logic [7:0]  sample_t;
  typedef logic [7:0]  ascii_t;
  typedef logic [15:0] period_t;

  // Command keys, upper case ASCII
  localparam ascii_t KEY_PLAY    = 8'h45;
  localparam ascii_t KEY_STOP    = 8'h44;
  localparam ascii_t KEY_BACK    = 8'h42;
  localparam ascii_t KEY_FORWARD = 8'h46;
  localparam ascii_t KEY_RESTART = 8'h52;

  // Sample period limits, in clocks per sample
  localparam period_t DEFAULT_PERIOD = 16'd40;
  localparam period_t RATE_STEP      = 16'd4;
  localparam period_t MIN_PERIOD     = 16'd16;
  localparam period_t MAX_PERIOD     = 16'd96;

  // Flash access timing
  localparam int unsigned READ_WAIT_CYCLES = 7;
  localparam int unsigned WAIT_CNT_W       = $clog2(READ_WAIT_CYCLES);
  typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;
  localparam wait_cnt_t WAIT_LAST = wait_cnt_t'(READ_WAIT_CYCLES - 1);

  // Top of the sample region
  localparam addr_t LAST_ADDR = 22'h01FFFF;

  // ============================================================
  // Control state and grouped signals
  // ============================================================
  typedef enum logic [2:0] {
    ST_INIT      = 3'd0,
    ST_STOP      = 3'd1,
    ST_PLAY      = 3'd2,
    ST_PLAY_BACK = 3'd3,
    ST_STOP_BACK = 3'd4,
    ST_RESTART   = 3'd5
  } play_state_e;

  typedef struct packed {
    logic playing;
    logic reverse;
    logic restart;
  } play_ctrl_t;

  typedef struct packed {
    logic up;
    logic down;
    logic to_default;
  } speed_cmd_t;

  typedef struct packed {
    addr_t addr;
    logic  ce_n;
    logic  oe_n;
  } flash_bus_t;

endpackage

`default_nettype wire
